//--- bench/dbusPathTb.sv
// Self-checking testbench for the DBUS section
// Fixed-seed random microinstructions, compared each cycle with a model
// of the VMA, the ramfile and the bus select rules

`timescale 1ns/100ps
`include "dbus_cfg.svh"

module dbusPathTb;

   localparam int INIT_WORDS   = `RAMFILE_DEPTH;
   localparam int RANDOM_OPS   = 2000;
   localparam int SLACK_CYCLES = 20;
   localparam int CLK_PERIOD   = 8;

   logic                           clk;
   logic                           reset;
   logic [0:`UADDR_WIDTH-1]        uAddr;
   dbusPkg::dbusSelT               dbusSel;
   dbusPkg::dbmSelT                dbmSel;
   dbusPkg::ramAddrSelT            ramAddrSel;
   logic [0:`RAMFILE_ADDR_WIDTH-1] cromRamAddr;
   logic                           ramWrite;
   logic                           vmaLoad;
   logic [0:`VMA_FLAGS_WIDTH-1]    vmaFlagsIn;
   logic [0:`WORD_WIDTH/2-1]       cromNumber;
   logic [0:`WORD_WIDTH-1]         dp;
   logic [0:`WORD_WIDTH-1]         memData;
   logic                           cacheHit;
   logic [0:2]                     piReqPri;
   logic [0:`WORD_WIDTH/2-1]       pcFlags;
   logic [0:`WORD_WIDTH-1]         dbus;

   integer seed;
   int     errors;
   int     checks;

   // Model state, numeric view (index 0 is machine bit 35)
   logic [`VMA_ADDR_WIDTH-1:0]  modelVma;
   logic [0:`VMA_FLAGS_WIDTH-1] modelFlags;
   logic [`WORD_WIDTH-1:0]      modelRam [0:`RAMFILE_DEPTH-1];

   dbusPath dbusPath_inst
   (
      .clk         (clk),
      .reset       (reset),
      .uAddr       (uAddr),
      .dbusSel     (dbusSel),
      .dbmSel      (dbmSel),
      .ramAddrSel  (ramAddrSel),
      .cromRamAddr (cromRamAddr),
      .ramWrite    (ramWrite),
      .vmaLoad     (vmaLoad),
      .vmaFlagsIn  (vmaFlagsIn),
      .cromNumber  (cromNumber),
      .dp          (dp),
      .memData     (memData),
      .cacheHit    (cacheHit),
      .piReqPri    (piReqPri),
      .pcFlags     (pcFlags),
      .dbus        (dbus)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Stimulus helpers

   function automatic logic [`WORD_WIDTH-1:0] randWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      return {hi[3:0], lo};
   endfunction

   task automatic clearInputs();
      uAddr       = '0;
      dbusSel     = dbusPkg::dbusSelDp;
      dbmSel      = dbusPkg::dbmSelMem;
      ramAddrSel  = dbusPkg::ramAddrCrom;
      cromRamAddr = '0;
      ramWrite    = 1'b0;
      vmaLoad     = 1'b0;
      vmaFlagsIn  = '0;
      cromNumber  = '0;
      dp          = '0;
      memData     = '0;
      cacheHit    = 1'b0;
      piReqPri    = '0;
      pcFlags     = '0;
   endtask

   task automatic driveRandom();
      logic [31:0]            r;
      logic [31:0]            u;
      logic [31:0]            v;
      logic [`WORD_WIDTH-1:0] w;
      r = $random(seed);
      u = $random(seed);
      v = $random(seed);
      w = randWord();
      // Half the datapath words fall in the AC block (bits 18 to 31 clear)
      if (r[0])
         w[17:4] = '0;
      dp          = w;
      memData     = randWord();
      dbusSel     = dbusPkg::dbusSelT'(r[2:1]);
      dbmSel      = dbusPkg::dbmSelT'(r[4:3]);
      ramAddrSel  = dbusPkg::ramAddrSelT'(r[5]);
      cromRamAddr = r[11:6];
      ramWrite    = (r[13:12] == 2'b00);
      vmaLoad     = (r[15:14] == 2'b00);
      cacheHit    = (r[17:16] == 2'b00);
      piReqPri    = r[20:18];
      vmaFlagsIn  = u[13:0];
      pcFlags     = u[31:14];
      cromNumber  = v[29:12];
      // About one cycle in eight at an excluded microaddress
      if (r[23:21] == 3'b000)
         uAddr = r[24] ? `FORCE_EXCLUDE_A : `FORCE_EXCLUDE_B;
      else
         uAddr = v[11:0];
   endtask

   //////////////////////////////////////////////////
   // Reference model

   // Microcode field or low six VMA bits
   function automatic logic [`RAMFILE_ADDR_WIDTH-1:0] pickRamIndex();
      if (ramAddrSel == dbusPkg::ramAddrVma)
         return modelVma[5:0];
      return cromRamAddr;
   endfunction

   function automatic logic [`WORD_WIDTH-1:0] expectDbus();
      logic [`WORD_WIDTH-1:0]   dpW;
      logic [`WORD_WIDTH-1:0]   dbmW;
      logic [`WORD_WIDTH-1:0]   ramW;
      logic [`WORD_WIDTH/2-1:0] numW;
      logic                     readOn;
      logic                     acRef;
      logic                     excluded;
      logic                     forced;
      dpW  = dp;
      numW = cromNumber;
      ramW = modelRam[pickRamIndex()];
      case (dbmSel)
         dbusPkg::dbmSelMem:
            dbmW = memData;
         dbusPkg::dbmSelDp:
            dbmW = dpW;
         dbusPkg::dbmSelDpSwap:
            dbmW = {dpW[17:0], dpW[35:18]};
         default:
            dbmW = {numW, numW};
      endcase
      // Force decode from the VMA of the last load
      readOn   = modelFlags[`VMA_READ_CYCLE_BIT];
      acRef    = !modelFlags[`VMA_PHYSICAL_BIT] && (modelVma[17:4] == 14'd0);
      excluded = (uAddr == `FORCE_EXCLUDE_A) || (uAddr == `FORCE_EXCLUDE_B);
      forced   = readOn && (cacheHit || (acRef && !excluded));
      case (dbusSel)
         dbusPkg::dbusSelFlags:
            return {pcFlags, 1'b0, piReqPri, 4'b1111, modelVma[9:0]};
         dbusPkg::dbusSelDp:
            return dpW;
         dbusPkg::dbusSelRamfile:
            return ramW;
         default:
            return forced ? ramW : dbmW;
      endcase
   endfunction

   // Compare just before the edge, then apply the edge to the model
   task automatic checkAndAdvance();
      logic [`WORD_WIDTH-1:0]        expected;
      logic [`WORD_WIDTH-1:0]        dpW;
      logic [`RAMFILE_ADDR_WIDTH-1:0] idx;
      #(CLK_PERIOD - 2);
      expected = expectDbus();
      idx      = pickRamIndex();
      checks++;
      if (dbus !== expected)
      begin
         errors++;
         $display("Error at %0d ns: dbus expected %h, actual %h",
                  $time, expected, dbus);
      end
      // Ramfile takes this cycle's bus word, old VMA picks the slot
      if (ramWrite)
         modelRam[idx] = expected;
      if (vmaLoad)
      begin
         dpW        = dp;
         modelVma   = dpW[`VMA_ADDR_WIDTH-1:0];
         modelFlags = vmaFlagsIn;
      end
      @(posedge clk);
      #1;
   endtask

   //////////////////////////////////////////////////
   // Test sequence

   initial
   begin
      seed       = 32'h68302321;
      errors     = 0;
      checks     = 0;
      modelVma   = '0;
      modelFlags = '0;
      clearInputs();
      reset = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      // Flags select right after reset, VMA bits still zero
      for (int i = 0; i < 4; i++)
      begin
         driveRandom();
         dbusSel  = dbusPkg::dbusSelFlags;
         vmaLoad  = 1'b0;
         ramWrite = 1'b0;
         checkAndAdvance();
      end
      // Fill every ramfile word through the datapath select
      for (int i = 0; i < INIT_WORDS; i++)
      begin
         driveRandom();
         dbusSel     = dbusPkg::dbusSelDp;
         ramAddrSel  = dbusPkg::ramAddrCrom;
         cromRamAddr = 6'(i);
         ramWrite    = 1'b1;
         vmaLoad     = 1'b0;
         checkAndAdvance();
      end
      // Random microinstructions
      for (int i = 0; i < RANDOM_OPS; i++)
      begin
         driveRandom();
         checkAndAdvance();
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // Watchdog sized from the test length plus slack
   initial
   begin
      #((INIT_WORDS + RANDOM_OPS + SLACK_CYCLES) * CLK_PERIOD);
      $display("Timeout: the test sequence did not finish in the expected time");
      $display("Regression failed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+include
hdl/dbusPkg.sv
hdl/vmaReg.sv
hdl/ramFile.sv
hdl/dbmMux.sv
hdl/dbusMux.sv
hdl/dbusPath.sv
bench/dbusPathTb.sv

//--- hdl/dbmMux.sv
// DBM source selector ahead of the DBUS multiplexer
// Picks memory data, the datapath, swapped halves or the number field

`timescale 1ns/100ps
`include "dbus_cfg.svh"

module dbmMux
(
   input  dbusPkg::dbmSelT           dbmSel,
   input  logic [0:`WORD_WIDTH-1]    memData,
   input  logic [0:`WORD_WIDTH-1]    dp,
   input  logic [0:`WORD_WIDTH/2-1]  cromNumber,
   output logic [0:`WORD_WIDTH-1]    dbm
);

   // Halves of the datapath word
   logic [0:`WORD_WIDTH/2-1] dpLeft;
   logic [0:`WORD_WIDTH/2-1] dpRight;

   assign dpLeft  = dp[0:`WORD_WIDTH/2-1];
   assign dpRight = dp[`WORD_WIDTH/2:`WORD_WIDTH-1];

   //////////////////////////////////////////////////
   // Four-way selector
   //////////////////////////////////////////////////

   always_comb
   begin
      case (dbmSel)
         dbusPkg::dbmSelMem:
            dbm = memData;
         dbusPkg::dbmSelDp:
            dbm = dp;
         dbusPkg::dbmSelDpSwap:
            // Left and right halves exchanged
            dbm = {dpRight, dpLeft};
         dbusPkg::dbmSelNumber:
            // Number field in both halves
            dbm = {cromNumber, cromNumber};
         default:
            dbm = memData;
      endcase
   end

endmodule

//--- hdl/dbusMux.sv
// DBUS multiplexer with the ramfile force for AC references and cache hits
// Purely combinational, the bus word is valid in the same cycle

`timescale 1ns/100ps
`include "dbus_cfg.svh"

module dbusMux
(
   input  logic [0:`UADDR_WIDTH-1]                         uAddr,
   input  dbusPkg::dbusSelT                                dbusSel,
   input  logic                                            cacheHit,
   input  logic [0:2]                                      piReqPri,
   input  logic [`WORD_WIDTH-`VMA_ADDR_WIDTH:`WORD_WIDTH-1] vmaAddr,
   input  logic [0:`VMA_FLAGS_WIDTH-1]                     vmaFlags,
   input  logic [0:`WORD_WIDTH/2-1]                        pcFlags,
   input  logic [0:`WORD_WIDTH-1]                          dp,
   input  logic [0:`WORD_WIDTH-1]                          ramData,
   input  logic [0:`WORD_WIDTH-1]                          dbm,
   output logic [0:`WORD_WIDTH-1]                          dbus
);

   logic readCycle;
   logic physical;
   logic acRef;
   logic uAddrExcluded;
   logic forceRamfile;

   //////////////////////////////////////////////////
   // VMA flag decode
   //////////////////////////////////////////////////

   assign readCycle = vmaFlags[`VMA_READ_CYCLE_BIT];
   assign physical  = vmaFlags[`VMA_PHYSICAL_BIT];

   // AC block is the lowest 16 words, never physical
   assign acRef = ~physical & (vmaAddr[18:31] == '0);

   // Two microaddresses where the AC force must stay off
   assign uAddrExcluded = (uAddr == `FORCE_EXCLUDE_A) |
                          (uAddr == `FORCE_EXCLUDE_B);

   //////////////////////////////////////////////////
   // Ramfile force
   //
   // Read cycle only
   // Cache hit forces at every microaddress
   //////////////////////////////////////////////////

   assign forceRamfile = readCycle & ((acRef & ~uAddrExcluded) | cacheHit);

   //////////////////////////////////////////////////
   // Bus source select
   //////////////////////////////////////////////////

   always_comb
   begin
      case (dbusSel)
         dbusPkg::dbusSelFlags:
            // PC flags, zero, priority, four ones, low VMA
            dbus = {pcFlags, 1'b0, piReqPri, 4'b1111, vmaAddr[26:35]};
         dbusPkg::dbusSelDp:
            dbus = dp;
         dbusPkg::dbusSelRamfile:
            dbus = ramData;
         dbusPkg::dbusSelDbm:
         begin
            // Ramfile stands in for memory on a forced read
            if (forceRamfile)
               dbus = ramData;
            else
               dbus = dbm;
         end
         default:
            dbus = dp;
      endcase
   end

endmodule

//--- hdl/dbusPath.sv
// Top of the DBUS section
// Takes one microinstruction per clock as loose fields plus environment
// inputs, and drives the DBUS word with zero latency

`timescale 1ns/100ps
`include "dbus_cfg.svh"

module dbusPath
(
   input  logic                           clk,
   input  logic                           reset,
   // Microinstruction fields
   input  logic [0:`UADDR_WIDTH-1]        uAddr,
   input  dbusPkg::dbusSelT               dbusSel,
   input  dbusPkg::dbmSelT                dbmSel,
   input  dbusPkg::ramAddrSelT            ramAddrSel,
   input  logic [0:`RAMFILE_ADDR_WIDTH-1] cromRamAddr,
   input  logic                           ramWrite,
   input  logic                           vmaLoad,
   input  logic [0:`VMA_FLAGS_WIDTH-1]    vmaFlagsIn,
   input  logic [0:`WORD_WIDTH/2-1]       cromNumber,
   // Environment
   input  logic [0:`WORD_WIDTH-1]         dp,
   input  logic [0:`WORD_WIDTH-1]         memData,
   input  logic                           cacheHit,
   input  logic [0:2]                     piReqPri,
   input  logic [0:`WORD_WIDTH/2-1]       pcFlags,
   output logic [0:`WORD_WIDTH-1]         dbus
);

   // Internal nets
   logic [`WORD_WIDTH-`VMA_ADDR_WIDTH:`WORD_WIDTH-1] vmaAddr;
   logic [0:`VMA_FLAGS_WIDTH-1]                     vmaFlags;
   logic [0:`WORD_WIDTH-1]                          ramData;
   logic [0:`WORD_WIDTH-1]                          dbm;

   //////////////////////////////////////////////////
   // Stateful blocks
   //////////////////////////////////////////////////

   vmaReg uVmaReg
   (
      .clk        (clk),
      .reset      (reset),
      .vmaLoad    (vmaLoad),
      .dp         (dp),
      .vmaFlagsIn (vmaFlagsIn),
      .vmaAddr    (vmaAddr),
      .vmaFlags   (vmaFlags)
   );

   // Written from the DBUS it feeds
   ramFile uRamFile
   (
      .clk         (clk),
      .ramWrite    (ramWrite),
      .ramAddrSel  (ramAddrSel),
      .cromRamAddr (cromRamAddr),
      .vmaAddr     (vmaAddr),
      .dbus        (dbus),
      .ramData     (ramData)
   );

   //////////////////////////////////////////////////
   // Bus selectors
   //////////////////////////////////////////////////

   dbmMux uDbmMux
   (
      .dbmSel     (dbmSel),
      .memData    (memData),
      .dp         (dp),
      .cromNumber (cromNumber),
      .dbm        (dbm)
   );

   dbusMux uDbusMux
   (
      .uAddr    (uAddr),
      .dbusSel  (dbusSel),
      .cacheHit (cacheHit),
      .piReqPri (piReqPri),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .pcFlags  (pcFlags),
      .dp       (dp),
      .ramData  (ramData),
      .dbm      (dbm),
      .dbus     (dbus)
   );

endmodule

//--- hdl/dbusPkg.sv
// Shared select encodings for the DBUS section
// Referenced by scoped name from the RTL and the bench

package dbusPkg;

   //////////////////////////////////////////////////
   // DBUS source select, microcode field

   typedef enum logic [1:0]
   {
      dbusSelFlags   = 2'd0,
      dbusSelDp      = 2'd1,
      dbusSelRamfile = 2'd2,
      dbusSelDbm     = 2'd3
   } dbusSelT;

   // DBM source select
   typedef enum logic [1:0]
   {
      dbmSelMem    = 2'd0,
      dbmSelDp     = 2'd1,
      dbmSelDpSwap = 2'd2,
      dbmSelNumber = 2'd3
   } dbmSelT;

   // Ramfile address source
   typedef enum logic
   {
      ramAddrCrom = 1'b0,
      ramAddrVma  = 1'b1
   } ramAddrSelT;

endpackage

//--- hdl/ramFile.sv
// 64-word ramfile holding the ACs and cached words
// Read is combinational, write takes the DBUS word at the clock edge
// Address comes from the microword or from the low VMA bits

`timescale 1ns/100ps
`include "dbus_cfg.svh"

module ramFile
(
   input  logic                                            clk,
   input  logic                                            ramWrite,
   input  dbusPkg::ramAddrSelT                             ramAddrSel,
   input  logic [0:`RAMFILE_ADDR_WIDTH-1]                  cromRamAddr,
   input  logic [`WORD_WIDTH-`VMA_ADDR_WIDTH:`WORD_WIDTH-1] vmaAddr,
   input  logic [0:`WORD_WIDTH-1]                          dbus,
   output logic [0:`WORD_WIDTH-1]                          ramData
);

   // Storage array, no reset
   logic [0:`WORD_WIDTH-1]         mem [0:`RAMFILE_DEPTH-1];

   // Selected location
   logic [0:`RAMFILE_ADDR_WIDTH-1] ramAddr;

   //////////////////////////////////////////////////
   // Address source
   //////////////////////////////////////////////////

   always_comb
   begin
      case (ramAddrSel)
         dbusPkg::ramAddrCrom:
            ramAddr = cromRamAddr;
         dbusPkg::ramAddrVma:
            // Low six VMA bits reach the AC block
            ramAddr = vmaAddr[`WORD_WIDTH-`RAMFILE_ADDR_WIDTH:`WORD_WIDTH-1];
         default:
            ramAddr = cromRamAddr;
      endcase
   end

   //////////////////////////////////////////////////
   // Read and write ports
   //////////////////////////////////////////////////

   // Asynchronous read
   // Same-cycle write is not seen until the next cycle
   assign ramData = mem[ramAddr];

   always_ff @(posedge clk)
   begin
      if (ramWrite)
      begin
         mem[ramAddr] <= dbus;
      end
   end

endmodule

//--- hdl/vmaReg.sv
// Virtual memory address register with its flag field
// Loaded from the datapath right part when microcode asserts vmaLoad

`timescale 1ns/100ps
`include "dbus_cfg.svh"

module vmaReg
(
   input  logic                                            clk,
   input  logic                                            reset,
   input  logic                                            vmaLoad,
   input  logic [0:`WORD_WIDTH-1]                          dp,
   input  logic [0:`VMA_FLAGS_WIDTH-1]                     vmaFlagsIn,
   output logic [`WORD_WIDTH-`VMA_ADDR_WIDTH:`WORD_WIDTH-1] vmaAddr,
   output logic [0:`VMA_FLAGS_WIDTH-1]                     vmaFlags
);

   //////////////////////////////////////////////////
   // Address and flags
   //
   // Address comes from dp bits 14 to 35
   // Flags come straight from the microword
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vmaAddr  <= '0;
         vmaFlags <= '0;
      end
      else if (vmaLoad)
      begin
         // Right part of the datapath only
         vmaAddr  <= dp[`WORD_WIDTH-`VMA_ADDR_WIDTH:`WORD_WIDTH-1];
         vmaFlags <= vmaFlagsIn;
      end
   end

endmodule

//--- include/dbus_cfg.svh
// Width and address constants for the DBUS section of the 36-bit slice
// Include in every RTL and bench file that sizes a word or tests a flag
// Bit 0 is the most significant bit of every word, bit 35 the least

`ifndef DBUS_CFG_SVH
`define DBUS_CFG_SVH

// Machine word, shared by datapath, DBUS, DBM, ramfile and memory
`define WORD_WIDTH 36

// VMA address occupies word bits 14 to 35
`define VMA_ADDR_WIDTH 22
`define VMA_FLAGS_WIDTH 14

// Flag positions within the VMA flag field
`define VMA_READ_CYCLE_BIT 3
`define VMA_PHYSICAL_BIT 8

// Ramfile geometry
`define RAMFILE_DEPTH 64
`define RAMFILE_ADDR_WIDTH 6

// Microaddresses that must not take the AC-reference force
`define UADDR_WIDTH 12
`define FORCE_EXCLUDE_A 12'o1146
`define FORCE_EXCLUDE_B 12'o3666

`endif

//--- run.sh
#!/bin/sh
# Build the DBUS testbench with Verilator, run it and scan the log

rm -f sim.log

verilator --binary --timescale 1ns/100ps -f flist.f --top-module dbusPathTb -o dbusPathTb \
   && ./obj_dir/dbusPathTb | tee sim.log \
   || { echo "Build or simulation did not complete"; exit 1; }

grep -q "Regression failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0
